// ==== source/phoenix_pkg.sv ====
package phoenix_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int XLEN        = 32;
    localparam int INDEX_WIDTH = 5;

    // Major opcodes handled by the core, anything else is a bubble
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011
    } opcode_t;

    // ALU operations
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_t;

    // Store size, same encoding as funct3[1:0]
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } store_width_t;

    // --------------------
    // Ports
    // --------------------
    typedef struct packed {
        logic            enable;
        logic [XLEN-1:0] address;
    } imem_request_t;

    // Single-cycle write strobe, word address, lane data and byte mask
    typedef struct packed {
        logic            strobe;
        logic [XLEN-1:0] address;
        logic [XLEN-1:0] data;
        logic [3:0]      mask;
    } store_request_t;

    typedef struct packed {
        logic                   enable;
        logic [INDEX_WIDTH-1:0] index;
        logic [XLEN-1:0]        data;
    } writeback_t;

    // --------------------
    // Pipeline payloads
    // --------------------
    typedef struct packed {
        logic [INDEX_WIDTH-1:0] read_index_1;
        logic [INDEX_WIDTH-1:0] read_index_2;
        logic                   read_enable_1;
        logic                   read_enable_2;
        logic [INDEX_WIDTH-1:0] write_index;
        logic                   write_enable;
        alu_op_t                alu_op;
        logic                   use_immediate;
        logic                   is_auipc;
        logic                   is_store;
        store_width_t           store_width;
        logic [XLEN-1:0]        immediate;
    } decoded_t;

    // Decoded instruction with its pc and both source values
    typedef struct packed {
        decoded_t        decoded;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] operand_1;
        logic [XLEN-1:0] operand_2;
    } execute_payload_t;

endpackage

// ==== source/instruction_decoder.sv ====
module instruction_decoder
(
    input  logic [phoenix_pkg::XLEN-1:0] instruction,
    output phoenix_pkg::decoded_t        decoded
);

    // Raw instruction fields
    phoenix_pkg::opcode_t          opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [phoenix_pkg::XLEN-1:0]  immediate_i;
    logic [phoenix_pkg::XLEN-1:0]  immediate_s;
    logic [phoenix_pkg::XLEN-1:0]  immediate_u;

    assign opcode = phoenix_pkg::opcode_t'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // --------------------
    // Immediates
    // --------------------
    assign immediate_i = {{20{instruction[31]}}, instruction[31:20]};
    assign immediate_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immediate_u = {instruction[31:12], 12'b0};

    // funct3 to ALU operation, alternate picks SUB or SRA
    function automatic phoenix_pkg::alu_op_t alu_select(input logic [2:0] f3, input logic alt);
        phoenix_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = alt ? phoenix_pkg::SUB : phoenix_pkg::ADD;
            3'b001:  op = phoenix_pkg::SLL;
            3'b010:  op = phoenix_pkg::SLT;
            3'b011:  op = phoenix_pkg::SLTU;
            3'b100:  op = phoenix_pkg::XOR;
            3'b101:  op = alt ? phoenix_pkg::SRA : phoenix_pkg::SRL;
            3'b110:  op = phoenix_pkg::OR;
            default: op = phoenix_pkg::AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        // Default is a bubble with no write and no store
        decoded              = '0;
        decoded.read_index_1 = instruction[19:15];
        decoded.read_index_2 = instruction[24:20];
        decoded.write_index  = instruction[11:7];
        decoded.alu_op       = phoenix_pkg::ADD;
        decoded.store_width  = phoenix_pkg::WORD;
        case (opcode)
            phoenix_pkg::OP:
            begin
                decoded.read_enable_1 = 1'b1;
                decoded.read_enable_2 = 1'b1;
                decoded.write_enable  = 1'b1;
                decoded.alu_op        = alu_select(funct3, funct7[5]);
            end
            phoenix_pkg::OP_IMM:
            begin
                decoded.read_enable_1 = 1'b1;
                decoded.write_enable  = 1'b1;
                decoded.use_immediate = 1'b1;
                decoded.immediate     = immediate_i;
                // Only SRAI carries the alternate bit, ADDI has no subtract form
                decoded.alu_op        = alu_select(funct3, funct7[5] && funct3 == 3'b101);
            end
            phoenix_pkg::LUI:
            begin
                decoded.write_enable  = 1'b1;
                decoded.use_immediate = 1'b1;
                decoded.immediate     = immediate_u;
                decoded.alu_op        = phoenix_pkg::PASS_B;
            end
            phoenix_pkg::AUIPC:
            begin
                decoded.write_enable  = 1'b1;
                decoded.use_immediate = 1'b1;
                decoded.is_auipc      = 1'b1;
                decoded.immediate     = immediate_u;
            end
            phoenix_pkg::STORE:
            begin
                // SB, SH and SW only
                if (!funct3[2] && funct3[1:0] != 2'b11)
                begin
                    decoded.read_enable_1 = 1'b1;
                    decoded.read_enable_2 = 1'b1;
                    decoded.use_immediate = 1'b1;
                    decoded.is_store      = 1'b1;
                    decoded.immediate     = immediate_s;
                    decoded.store_width   = phoenix_pkg::store_width_t'(funct3[1:0]);
                end
            end
            default:
            begin
            end
        endcase
    end

endmodule

// ==== source/hazard_forward_unit.sv ====
module hazard_forward_unit
(
    input  logic [phoenix_pkg::INDEX_WIDTH-1:0] source_index,
    input  logic [phoenix_pkg::XLEN-1:0]        register_data,
    input  phoenix_pkg::writeback_t             ex_writeback,
    input  phoenix_pkg::writeback_t             mw_writeback,
    output logic [phoenix_pkg::XLEN-1:0]        operand
);

    logic ex_match;
    logic mw_match;

    // x0 always reads zero, so it is never forwarded
    assign ex_match = ex_writeback.enable && ex_writeback.index == source_index
                      && source_index != '0;
    assign mw_match = mw_writeback.enable && mw_writeback.index == source_index
                      && source_index != '0;

    // Youngest result wins: execute, then writeback, then register file
    always_comb
    begin
        if (ex_match)
            operand = ex_writeback.data;
        else if (mw_match)
            operand = mw_writeback.data;
        else
            operand = register_data;
    end

endmodule

// ==== source/register_file.sv ====
module register_file
#(
    parameter int REGISTER_COUNT = 32
)
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic [phoenix_pkg::INDEX_WIDTH-1:0] read_index_1,
    input  logic [phoenix_pkg::INDEX_WIDTH-1:0] read_index_2,
    output logic [phoenix_pkg::XLEN-1:0]        read_data_1,
    output logic [phoenix_pkg::XLEN-1:0]        read_data_2,
    input  phoenix_pkg::writeback_t             write
);

    logic [phoenix_pkg::XLEN-1:0] registers [REGISTER_COUNT];

    // Write at the end of the writeback cycle, x0 stays zero
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < REGISTER_COUNT; i++)
                registers[i] <= '0;
        end
        else if (write.enable && write.index != '0 && write.index < REGISTER_COUNT)
            registers[write.index] <= write.data;
    end

    // Combinational reads, indices past the array read as zero
    assign read_data_1 = (read_index_1 < REGISTER_COUNT) ? registers[read_index_1] : '0;
    assign read_data_2 = (read_index_2 < REGISTER_COUNT) ? registers[read_index_2] : '0;

    // The decoder does not know the register count, a reduced file relies on the program
    assert property (@(posedge clk) disable iff (reset)
        write.enable |-> write.index < REGISTER_COUNT);

endmodule

// ==== source/fetch_decode_stage.sv ====
module fetch_decode_stage
#(
    parameter logic [phoenix_pkg::XLEN-1:0] RESET_ADDRESS = 32'h1000_0000
)
(
    input  logic                                clk,
    input  logic                                reset,
    output phoenix_pkg::imem_request_t          imem_request,
    input  logic [phoenix_pkg::XLEN-1:0]        instruction,
    output logic [phoenix_pkg::INDEX_WIDTH-1:0] read_index_1,
    output logic [phoenix_pkg::INDEX_WIDTH-1:0] read_index_2,
    input  logic [phoenix_pkg::XLEN-1:0]        read_data_1,
    input  logic [phoenix_pkg::XLEN-1:0]        read_data_2,
    input  phoenix_pkg::writeback_t             ex_writeback,
    input  phoenix_pkg::writeback_t             mw_writeback,
    output phoenix_pkg::execute_payload_t       execute_payload
);

    logic [phoenix_pkg::XLEN-1:0] pc;
    phoenix_pkg::decoded_t        decoded;
    logic [phoenix_pkg::XLEN-1:0] operand_1;
    logic [phoenix_pkg::XLEN-1:0] operand_2;

    // --------------------
    // Fetch
    // --------------------

    // Fetch starts at the reset address and moves one word per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= RESET_ADDRESS;
        end
        else
        begin
            pc <= pc + 32'd4;
        end
    end

    // Memory answers in the same cycle
    // Enable drops only while reset is held
    assign imem_request.enable  = !reset;
    assign imem_request.address = pc;

    // --------------------
    // Decode
    // --------------------
    instruction_decoder i_instruction_decoder
    (
        .instruction (instruction),
        .decoded     (decoded)
    );

    // Unused sources read x0, which also keeps them out of forwarding
    assign read_index_1 = decoded.read_enable_1 ? decoded.read_index_1 : '0;
    assign read_index_2 = decoded.read_enable_2 ? decoded.read_index_2 : '0;

    // One forward unit per source operand
    hazard_forward_unit i_forward_source_1
    (
        .source_index  (read_index_1),
        .register_data (read_data_1),
        .ex_writeback  (ex_writeback),
        .mw_writeback  (mw_writeback),
        .operand       (operand_1)
    );

    hazard_forward_unit i_forward_source_2
    (
        .source_index  (read_index_2),
        .register_data (read_data_2),
        .ex_writeback  (ex_writeback),
        .mw_writeback  (mw_writeback),
        .operand       (operand_2)
    );

    // --------------------
    // Decode to execute
    // --------------------
    always_ff @(posedge clk)
    begin
        execute_payload.decoded   <= decoded;
        execute_payload.pc        <= pc;
        execute_payload.operand_1 <= operand_1;
        execute_payload.operand_2 <= operand_2;
        // Bubble into execute while held in reset
        if (reset)
        begin
            execute_payload.decoded.write_enable <= 1'b0;
            execute_payload.decoded.is_store     <= 1'b0;
        end
    end

    // No jumps exist, so the fetch address stays word aligned from reset on
    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== source/execute_stage.sv ====
module execute_stage
(
    input  logic                          clk,
    input  logic                          reset,
    input  phoenix_pkg::execute_payload_t execute_payload,
    output phoenix_pkg::writeback_t       ex_writeback,
    output phoenix_pkg::writeback_t       mw_writeback,
    output phoenix_pkg::store_request_t   store_request
);

    phoenix_pkg::decoded_t        decoded;
    logic [phoenix_pkg::XLEN-1:0] operand_a;
    logic [phoenix_pkg::XLEN-1:0] operand_b;
    logic [4:0]                   shift_amount;
    logic [phoenix_pkg::XLEN-1:0] alu_result;
    phoenix_pkg::store_request_t  store_next;

    assign decoded = execute_payload.decoded;

    // --------------------
    // ALU
    // --------------------

    // AUIPC adds to its own pc, stores add the offset to rs1
    assign operand_a    = decoded.is_auipc ? execute_payload.pc : execute_payload.operand_1;
    assign operand_b    = decoded.use_immediate ? decoded.immediate : execute_payload.operand_2;
    assign shift_amount = operand_b[4:0];

    always_comb
    begin
        case (decoded.alu_op)
            phoenix_pkg::ADD:    alu_result = operand_a + operand_b;
            phoenix_pkg::SUB:    alu_result = operand_a - operand_b;
            phoenix_pkg::SLL:    alu_result = operand_a << shift_amount;
            phoenix_pkg::SLT:    alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            phoenix_pkg::SLTU:   alu_result = {31'b0, operand_a < operand_b};
            phoenix_pkg::XOR:    alu_result = operand_a ^ operand_b;
            phoenix_pkg::SRL:    alu_result = operand_a >> shift_amount;
            phoenix_pkg::SRA:    alu_result = $signed(operand_a) >>> shift_amount;
            phoenix_pkg::OR:     alu_result = operand_a | operand_b;
            phoenix_pkg::AND:    alu_result = operand_a & operand_b;
            phoenix_pkg::PASS_B: alu_result = operand_b;
            default:             alu_result = '0;
        endcase
    end

    // Result seen by the forward units in the same cycle
    assign ex_writeback.enable = decoded.write_enable;
    assign ex_writeback.index  = decoded.write_index;
    assign ex_writeback.data   = alu_result;

    // --------------------
    // Store lanes
    // --------------------

    // ALU sum is the byte address, lanes are little endian
    always_comb
    begin
        store_next.strobe  = decoded.is_store;
        store_next.address = {alu_result[phoenix_pkg::XLEN-1:2], 2'b00};
        case (decoded.store_width)
            phoenix_pkg::BYTE:
            begin
                store_next.data = {4{execute_payload.operand_2[7:0]}};
                store_next.mask = 4'b0001 << alu_result[1:0];
            end
            phoenix_pkg::HALF:
            begin
                store_next.data = {2{execute_payload.operand_2[15:0]}};
                store_next.mask = 4'b0011 << {alu_result[1], 1'b0};
            end
            default:
            begin
                store_next.data = execute_payload.operand_2;
                store_next.mask = 4'b1111;
            end
        endcase
    end

    // --------------------
    // Execute to writeback
    // --------------------
    always_ff @(posedge clk)
    begin
        mw_writeback  <= ex_writeback;
        store_request <= store_next;
        if (reset)
        begin
            mw_writeback.enable  <= 1'b0;
            store_request.strobe <= 1'b0;
        end
    end

    // A decoded store never writes a register
    assert property (@(posedge clk) disable iff (reset)
        !(store_request.strobe && mw_writeback.enable));

endmodule

// ==== source/phoenix_lite.sv ====
module phoenix_lite
#(
    parameter logic [phoenix_pkg::XLEN-1:0] RESET_ADDRESS  = 32'h1000_0000,
    parameter int                           REGISTER_COUNT = 32
)
(
    input  logic                         clk,
    input  logic                         reset,
    output phoenix_pkg::imem_request_t   imem_request,
    input  logic [phoenix_pkg::XLEN-1:0] instruction,
    output phoenix_pkg::store_request_t  store_request
);

    // Register file read ports
    logic [phoenix_pkg::INDEX_WIDTH-1:0] read_index_1;
    logic [phoenix_pkg::INDEX_WIDTH-1:0] read_index_2;
    logic [phoenix_pkg::XLEN-1:0]        read_data_1;
    logic [phoenix_pkg::XLEN-1:0]        read_data_2;

    // Results from execute and writeback
    phoenix_pkg::writeback_t       ex_writeback;
    phoenix_pkg::writeback_t       mw_writeback;
    phoenix_pkg::execute_payload_t execute_payload;

    fetch_decode_stage
    #(
        .RESET_ADDRESS (RESET_ADDRESS)
    )
    i_fetch_decode_stage
    (
        .clk             (clk),
        .reset           (reset),
        .imem_request    (imem_request),
        .instruction     (instruction),
        .read_index_1    (read_index_1),
        .read_index_2    (read_index_2),
        .read_data_1     (read_data_1),
        .read_data_2     (read_data_2),
        .ex_writeback    (ex_writeback),
        .mw_writeback    (mw_writeback),
        .execute_payload (execute_payload)
    );

    execute_stage i_execute_stage
    (
        .clk             (clk),
        .reset           (reset),
        .execute_payload (execute_payload),
        .ex_writeback    (ex_writeback),
        .mw_writeback    (mw_writeback),
        .store_request   (store_request)
    );

    // Written from the writeback stage
    register_file
    #(
        .REGISTER_COUNT (REGISTER_COUNT)
    )
    i_register_file
    (
        .clk          (clk),
        .reset        (reset),
        .read_index_1 (read_index_1),
        .read_index_2 (read_index_2),
        .read_data_1  (read_data_1),
        .read_data_2  (read_data_2),
        .write        (mw_writeback)
    );

endmodule

// ==== tb/store_checker.sv ====
module store_checker
#(
    parameter logic [31:0] RESET_ADDRESS = 32'h1000_0000
)
(
    input  logic                        clk,
    input  logic                        reset,
    input  phoenix_pkg::imem_request_t  imem_request,
    input  logic [31:0]                 instruction,
    input  phoenix_pkg::store_request_t store_request,
    output int                          error_count,
    output int                          store_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // Architectural state of the model without pipeline timing
    logic [31:0]                 registers [32];
    phoenix_pkg::store_request_t expected_stores [$];
    int                          expected_cycles [$];
    logic [31:0]                 expected_pc;
    int                          cycle;

    initial
    begin
        error_count = 0;
        store_count = 0;
        cycle       = 0;
        expected_pc = RESET_ADDRESS;
        for (int i = 0; i < 32; i++)
            registers[i] = '0;
    end

    // --------------------
    // Model
    // --------------------

    // RV32I integer result for funct3
    // The alt bit selects SUB or SRA
    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:
                if (alt)
                    return a - b;
                else
                    return a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101:
                if (alt)
                    return $signed(a) >>> b[4:0];
                else
                    return a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic write_register(input logic [4:0] rd, input logic [31:0] value);
        // x0 is hardwired to zero
        if (rd != 5'd0)
            registers[rd] = value;
    endtask

    task automatic execute_instruction(input logic [31:0] word, input logic [31:0] pc);
        logic [2:0]                  f3;
        logic [31:0]                 a;
        logic [31:0]                 b;
        logic [31:0]                 imm_i;
        logic [31:0]                 imm_s;
        logic [31:0]                 byte_address;
        phoenix_pkg::store_request_t store;
        f3    = word[14:12];
        a     = registers[word[19:15]];
        b     = registers[word[24:20]];
        imm_i = {{20{word[31]}}, word[31:20]};
        imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
        case (word[6:0])
            7'h33: write_register(word[11:7], alu(f3, word[30], a, b));
            // Only SRAI has an alternate form among the immediates
            7'h13: write_register(word[11:7], alu(f3, f3 == 3'b101 && word[30], a, imm_i));
            7'h37: write_register(word[11:7], {word[31:12], 12'h000});
            7'h17: write_register(word[11:7], pc + {word[31:12], 12'h000});
            7'h23:
            begin
                // SB, SH and SW strobe two cycles after their fetch
                if (f3 <= 3'b010)
                begin
                    byte_address  = a + imm_s;
                    store.strobe  = 1'b1;
                    store.address = {byte_address[31:2], 2'b00};
                    if (f3 == 3'b000)
                    begin
                        store.data = {4{b[7:0]}};
                        store.mask = 4'b0001 << byte_address[1:0];
                    end
                    else if (f3 == 3'b001)
                    begin
                        store.data = {2{b[15:0]}};
                        store.mask = byte_address[1] ? 4'b1100 : 4'b0011;
                    end
                    else
                    begin
                        store.data = b;
                        store.mask = 4'b1111;
                    end
                    expected_stores.push_back(store);
                    expected_cycles.push_back(cycle + 2);
                end
            end
            default:
            begin
                // Unsupported opcode runs as a bubble
            end
        endcase
    endtask

    // --------------------
    // Comparison
    // --------------------
    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected %08h, actual %08h in cycle %0d",
                     name, expected, actual, cycle);
            error_count++;
        end
    endtask

    task automatic check_store();
        phoenix_pkg::store_request_t expected;
        logic                        due;
        int                          due_cycle;
        due = expected_cycles.size() != 0 && expected_cycles[0] == cycle;
        if (store_request.strobe === 1'b1 && !due)
        begin
            $display("Store strobe in cycle %0d at address %08h has no store fetched for it",
                     cycle, store_request.address);
            error_count++;
        end
        else if (due)
        begin
            expected  = expected_stores.pop_front();
            due_cycle = expected_cycles.pop_front();
            if (store_request.strobe !== 1'b1)
            begin
                $display("Store due in cycle %0d never strobed", due_cycle);
                error_count++;
            end
            else
            begin
                compare_field("store_request.address", expected.address, store_request.address);
                compare_field("store_request.data", expected.data, store_request.data);
                compare_field("store_request.mask", 32'(expected.mask), 32'(store_request.mask));
                store_count++;
            end
        end
    endtask

    // Samples the cycle that ends at this edge
    always @(posedge clk)
    begin
        // Before the first edge the DUT flops are still unknown
        if (cycle > 0)
        begin
            // Fetch is enabled in every cycle outside reset
            if (imem_request.enable !== !reset)
            begin
                $display("Mismatch imem_request.enable: expected %h, actual %h in cycle %0d",
                         !reset, imem_request.enable, cycle);
                error_count++;
            end
            check_store();
        end
        if (reset)
        begin
            if (expected_cycles.size() != 0)
            begin
                $display("A store was still pending when reset arrived in cycle %0d", cycle);
                error_count++;
            end
            expected_stores.delete();
            expected_cycles.delete();
            for (int i = 0; i < 32; i++)
                registers[i] = '0;
            expected_pc = RESET_ADDRESS;
        end
        else
        begin
            // Core issues one word per cycle from the reset address on
            if (imem_request.address !== expected_pc)
            begin
                $display("Mismatch imem_request.address: expected %08h, actual %08h in cycle %0d",
                         expected_pc, imem_request.address, cycle);
                error_count++;
            end
            execute_instruction(instruction, expected_pc);
            expected_pc = expected_pc + 32'd4;
        end
        cycle++;
    end

endmodule

// ==== tb/tb_phoenix_lite.sv ====
module tb_phoenix_lite;

    timeunit 1ns;
    timeprecision 1ps;

    // --------------------
    // Run constants
    // --------------------
    localparam logic [31:0] RESET_ADDRESS  = 32'h1000_0000;
    localparam int unsigned SEED           = 32'h427a8e1c;
    localparam int          CLOCK_PERIOD   = 40;
    localparam int          TEST_COUNT     = 4;
    localparam int          PROGRAM_LENGTH = 64;
    localparam int          MEMORY_WORDS   = 256;
    localparam int          WATCHDOG_NS    = TEST_COUNT * (PROGRAM_LENGTH + 10) * CLOCK_PERIOD * 2;

    logic                        clk;
    logic                        reset;
    phoenix_pkg::imem_request_t  imem_request;
    logic [31:0]                 instruction;
    phoenix_pkg::store_request_t store_request;
    logic [31:0]                 program_memory [MEMORY_WORDS];
    logic [31:0]                 word_offset;
    int                          error_count;
    int                          store_count;

    always #(CLOCK_PERIOD / 2) clk = ~clk;

    // Same-cycle instruction memory
    // Addresses outside the array read as a bubble
    assign word_offset = (imem_request.address - RESET_ADDRESS) >> 2;
    assign instruction = (word_offset < MEMORY_WORDS) ? program_memory[word_offset] : 32'h0;

    phoenix_lite
    #(
        .RESET_ADDRESS  (RESET_ADDRESS),
        .REGISTER_COUNT (32)
    )
    i_phoenix_lite
    (
        .clk           (clk),
        .reset         (reset),
        .imem_request  (imem_request),
        .instruction   (instruction),
        .store_request (store_request)
    );

    store_checker
    #(
        .RESET_ADDRESS (RESET_ADDRESS)
    )
    i_store_checker
    (
        .clk           (clk),
        .reset         (reset),
        .imem_request  (imem_request),
        .instruction   (instruction),
        .store_request (store_request),
        .error_count   (error_count),
        .store_count   (store_count)
    );

    // --------------------
    // Program generation
    // --------------------

    // Opcode 0 is a bubble and the upper bits carry the word index
    function automatic logic [31:0] fill_word(input int index);
        return {25'(index), 7'b0000000};
    endfunction

    // The forwarding test stays on x1..x3 and the x0 test includes x0
    function automatic logic [4:0] pick_register(input int test);
        case (test)
            1: return 5'($urandom_range(2) + 1);
            2: return 5'($urandom_range(3));
            3: return 5'($urandom_range(7));
            default: return 5'($urandom_range(31));
        endcase
    endfunction

    function automatic logic [31:0] random_compute(input int test, input logic [4:0] rd);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          kind;
        f3   = 3'($urandom_range(7));
        imm  = 12'($urandom);
        kind = (test == 2) ? $urandom_range(3) : $urandom_range(1);
        // Alternate encoding only for SUB, SRA and SRAI
        f7   = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1) == 1) ? 7'h20 : 7'h00;
        case (kind)
            0: return {f7, pick_register(test), pick_register(test), f3, rd, 7'h33};
            1:
            begin
                if (f3 == 3'b001 || f3 == 3'b101)
                    imm = {f7, imm[4:0]};
                return {imm, pick_register(test), f3, rd, 7'h13};
            end
            2: return {20'($urandom), rd, 7'h37};
            default: return {20'($urandom), rd, 7'h17};
        endcase
    endfunction

    function automatic logic [31:0] random_store(input logic [4:0] data_register,
                                                 input logic [4:0] base_register,
                                                 input logic [2:0] width);
        logic [11:0] imm;
        imm = 12'($urandom);
        return {imm[11:5], data_register, base_register, width, imm[4:0], 7'h23};
    endfunction

    // Each compute is followed by a store of its destination
    task automatic load_program(input int test);
        logic [4:0] rd;
        logic [2:0] width;
        for (int i = 0; i < MEMORY_WORDS; i++)
            program_memory[i] <= fill_word(i);
        for (int i = 0; i < PROGRAM_LENGTH; i += 2)
        begin
            rd    = pick_register(test);
            width = (test == 3) ? 3'($urandom_range(2)) : 3'b010;
            program_memory[i]     <= random_compute(test, rd);
            program_memory[i + 1] <= random_store(rd, pick_register(test), width);
        end
    endtask

    task automatic wait_for_fetch(input logic [31:0] address);
        do
            @(posedge clk);
        while (!(imem_request.enable === 1'b1 && imem_request.address == address));
    endtask

    function automatic string test_name(input int test);
        case (test)
            0: return "arithmetic";
            1: return "forwarding";
            2: return "upper immediates and x0";
            default: return "store lanes";
        endcase
    endfunction

    // --------------------
    // Test sequence
    // --------------------
    initial
    begin
        int passed;
        int failed;
        int last_errors;
        int last_stores;
        int test_errors;
        int test_stores;
        void'($urandom(SEED));
        clk         = 1'b0;
        reset       = 1'b1;
        passed      = 0;
        failed      = 0;
        last_errors = 0;
        last_stores = 0;
        for (int i = 0; i < MEMORY_WORDS; i++)
            program_memory[i] = fill_word(i);
        for (int test = 0; test < TEST_COUNT; test++)
        begin
            @(posedge clk);
            reset <= 1'b1;
            load_program(test);
            repeat (3) @(posedge clk);
            reset <= 1'b0;
            // Every store has drained three words past the program
            wait_for_fetch(RESET_ADDRESS + 32'(4 * (PROGRAM_LENGTH + 3)));
            @(negedge clk);
            test_errors = error_count - last_errors;
            test_stores = store_count - last_stores;
            last_errors = error_count;
            last_stores = store_count;
            if (test_stores != PROGRAM_LENGTH / 2)
                $display("Test %0d expected %0d stores but %0d were checked",
                         test, PROGRAM_LENGTH / 2, test_stores);
            if (test_errors == 0 && test_stores == PROGRAM_LENGTH / 2)
            begin
                passed++;
                $display("Test %0d %s: passed, %0d stores", test, test_name(test), test_stores);
            end
            else
            begin
                failed++;
                $display("Test %0d %s: failed, %0d errors", test, test_name(test), test_errors);
            end
        end
        $display("Tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Bounded by twice the expected run length
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== phoenix_lite.f ====
source/phoenix_pkg.sv
source/instruction_decoder.sv
source/hazard_forward_unit.sv
source/register_file.sv
source/fetch_decode_stage.sv
source/execute_stage.sv
source/phoenix_lite.sv
tb/store_checker.sv
tb/tb_phoenix_lite.sv
